// File: alu.sv
`timescale 1ns/1ns

module alu (
  input  rvCore_pkg::aluOpType  aluOp,
  input  rvCore_pkg::branchType branchKind,
  input  logic [31:0]           a,
  input  logic [31:0]           b,
  output logic [31:0]           result,
  output logic                  taken
);

  always_comb begin
    case (aluOp)
      rvCore_pkg::ALU_ADD:  result = a + b;
      rvCore_pkg::ALU_SUB:  result = a - b;
      rvCore_pkg::ALU_LUI:  result = b; // upper immediate already shifted.
      rvCore_pkg::ALU_SLL:  result = a << b[4:0];
      rvCore_pkg::ALU_SRL:  result = a >> b[4:0];
      rvCore_pkg::ALU_SRA:  result = $signed(a) >>> b[4:0];
      rvCore_pkg::ALU_XOR:  result = a ^ b;
      rvCore_pkg::ALU_OR:   result = a | b;
      rvCore_pkg::ALU_AND:  result = a & b;
      rvCore_pkg::ALU_SLT:  result = {31'd0, $signed(a) < $signed(b)};
      rvCore_pkg::ALU_SLTU: result = {31'd0, a < b};
      default:              result = '0;
    endcase
  end

  // branch compare, a is rs1 and b is rs2.
  always_comb begin
    case (branchKind)
      rvCore_pkg::BRANCH_BEQ:  taken = (a == b);
      rvCore_pkg::BRANCH_BNE:  taken = (a != b);
      rvCore_pkg::BRANCH_BLT:  taken = ($signed(a) < $signed(b));
      rvCore_pkg::BRANCH_BGE:  taken = ($signed(a) >= $signed(b));
      rvCore_pkg::BRANCH_BLTU: taken = (a < b);
      rvCore_pkg::BRANCH_BGEU: taken = (a >= b);
      default:                 taken = 1'b0;
    endcase
  end

endmodule

// File: compile.f
+incdir+.
rvCore_pkg.sv
control.sv
alu.sv
regFile.sv
memArbiter.sv
unifiedMem.sv
core.sv
cpuTop.sv
cpuTop_properties.sv
tb_cpuTop.sv

// File: control.sv
`timescale 1ns/1ns

module control (
  input  rvCore_pkg::instructionType instruction,
  output rvCore_pkg::controlType     control
);

  always_comb begin
    control = '0;

    case (instruction.opcode)
      rvCore_pkg::OP_IMM: begin
        control.encoding = rvCore_pkg::I_TYPE;
        control.regWrite = 1'b1;
        control.aluSrc   = 1'b1;
      end
      rvCore_pkg::OP: begin
        control.encoding = rvCore_pkg::R_TYPE;
        control.regWrite = 1'b1;
      end
      rvCore_pkg::LUI: begin
        control.encoding = rvCore_pkg::U_TYPE;
        control.regWrite = 1'b1;
        control.aluSrc   = 1'b1; // immediate passes straight through.
        control.aluOp    = rvCore_pkg::ALU_LUI;
      end
      rvCore_pkg::LOAD: begin
        control.encoding = rvCore_pkg::I_TYPE;
        control.regWrite = 1'b1;
        control.aluSrc   = 1'b1;
        control.memRead  = 1'b1;
        control.memToReg = 1'b1;
      end
      rvCore_pkg::STORE: begin
        control.encoding = rvCore_pkg::S_TYPE;
        control.aluSrc   = 1'b1;
        control.memWrite = 1'b1;
      end
      rvCore_pkg::BRANCH: begin
        control.encoding = rvCore_pkg::B_TYPE;
        control.isBranch = 1'b1;
      end
      rvCore_pkg::SYSTEM: begin
        // ecall only, ebreak has rs2 = 1.
        control.halt = (instruction.funct3 == 3'b000) && (instruction.funct7 == 7'd0)
                       && (instruction.rs2 == 5'd0);
      end
      default: ; // unknown opcode, no-op.
    endcase

    if (instruction.opcode == rvCore_pkg::OP || instruction.opcode == rvCore_pkg::OP_IMM) begin
      case (instruction.funct3)
        3'b000: begin
          // addi has no sub form.
          if (instruction.opcode == rvCore_pkg::OP && instruction.funct7[5])
            control.aluOp = rvCore_pkg::ALU_SUB;
          else
            control.aluOp = rvCore_pkg::ALU_ADD;
        end
        3'b001: control.aluOp = rvCore_pkg::ALU_SLL;
        3'b010: control.aluOp = rvCore_pkg::ALU_SLT;
        3'b011: control.aluOp = rvCore_pkg::ALU_SLTU;
        3'b100: control.aluOp = rvCore_pkg::ALU_XOR;
        3'b101: control.aluOp = instruction.funct7[5] ? rvCore_pkg::ALU_SRA : rvCore_pkg::ALU_SRL;
        3'b110: control.aluOp = rvCore_pkg::ALU_OR;
        default: control.aluOp = rvCore_pkg::ALU_AND;
      endcase
    end

    if (instruction.opcode == rvCore_pkg::BRANCH) begin
      case (instruction.funct3)
        3'b000: control.branchKind = rvCore_pkg::BRANCH_BEQ;
        3'b001: control.branchKind = rvCore_pkg::BRANCH_BNE;
        3'b100: control.branchKind = rvCore_pkg::BRANCH_BLT;
        3'b101: control.branchKind = rvCore_pkg::BRANCH_BGE;
        3'b110: control.branchKind = rvCore_pkg::BRANCH_BLTU;
        3'b111: control.branchKind = rvCore_pkg::BRANCH_BGEU;
        default: control.branchKind = rvCore_pkg::BRANCH_NONE;
      endcase
    end
  end

endmodule

// File: core.sv
`timescale 1ns/1ns
`include "rv_config.svh"

module core (
  input  logic                  clk,
  input  logic                  arstN,
  input  logic                  start,
  output rvCore_pkg::memReqType coreReq,
  input  logic                  coreGnt,
  input  logic                  coreRdValid,
  input  logic [31:0]           rdata,
  output logic                  done
);

  rvCore_pkg::coreStateType   state;
  rvCore_pkg::instructionType ir;
  rvCore_pkg::controlType     ctrl;
  logic [31:0] pc;
  logic [31:0] irWord;
  logic [31:0] imm;
  logic [31:0] opA;
  logic [31:0] opB;
  logic [31:0] aluOut;
  logic [31:0] mdr;
  logic [31:0] rs1Data;
  logic [31:0] rs2Data;
  logic [31:0] aluB;
  logic [31:0] aluResult;
  logic [31:0] wbData;
  logic        taken;
  logic        waitRd;  // granted read, data not back yet.
  logic        regWe;

  assign irWord = ir;

  control i_control (.instruction(ir), .control(ctrl));

  alu i_alu (
    .aluOp(ctrl.aluOp), .branchKind(ctrl.branchKind),
    .a(opA), .b(aluB), .result(aluResult), .taken(taken)
  );

  assign regWe  = (state == rvCore_pkg::S_WB) && ctrl.regWrite;
  assign wbData = ctrl.memToReg ? mdr : aluOut;

  regFile i_regFile (
    .clk(clk), .arstN(arstN), .rs1(ir.rs1), .rs2(ir.rs2), .rd(ir.rd),
    .we(regWe), .wdata(wbData), .rdata1(rs1Data), .rdata2(rs2Data)
  );

  always_comb begin
    case (ctrl.encoding)
      rvCore_pkg::I_TYPE: imm = {{20{irWord[31]}}, irWord[31:20]};
      rvCore_pkg::S_TYPE: imm = {{20{irWord[31]}}, irWord[31:25], irWord[11:7]};
      rvCore_pkg::B_TYPE: imm = {{19{irWord[31]}}, irWord[31], irWord[7],
                                 irWord[30:25], irWord[11:8], 1'b0};
      rvCore_pkg::U_TYPE: imm = {irWord[31:12], 12'd0};
      default:            imm = '0;
    endcase
  end

  assign aluB = ctrl.aluSrc ? imm : opB;

  always_comb begin
    coreReq.req   = ~waitRd && (state == rvCore_pkg::S_FETCH || state == rvCore_pkg::S_MEM);
    coreReq.we    = (state == rvCore_pkg::S_MEM) && ctrl.memWrite;
    coreReq.addr  = (state == rvCore_pkg::S_FETCH) ? pc[`ADDR_BITS+1:2]
                                                   : aluOut[`ADDR_BITS+1:2];
    coreReq.wdata = opB;
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state  <= rvCore_pkg::S_IDLE;
      pc     <= 32'(`RESET_PC);
      waitRd <= 1'b0;
    end else begin
      case (state)
        rvCore_pkg::S_IDLE: if (start) state <= rvCore_pkg::S_FETCH;
        rvCore_pkg::S_FETCH: begin
          if (coreGnt) waitRd <= 1'b1;
          if (coreRdValid) begin
            waitRd <= 1'b0;
            state  <= rvCore_pkg::S_DECODE;
          end
        end
        rvCore_pkg::S_DECODE: state <= rvCore_pkg::S_EXEC;
        rvCore_pkg::S_EXEC: begin
          pc <= (ctrl.isBranch && taken) ? pc + imm : pc + 32'd4;
          if (ctrl.halt) state <= rvCore_pkg::S_HALT;
          else if (ctrl.memRead || ctrl.memWrite) state <= rvCore_pkg::S_MEM;
          else if (ctrl.regWrite) state <= rvCore_pkg::S_WB;
          else state <= rvCore_pkg::S_FETCH;
        end
        rvCore_pkg::S_MEM: begin
          if (coreGnt && ctrl.memWrite) state <= rvCore_pkg::S_FETCH; // store done at grant.
          else if (coreGnt) waitRd <= 1'b1;
          if (coreRdValid) begin
            waitRd <= 1'b0;
            state  <= rvCore_pkg::S_WB;
          end
        end
        rvCore_pkg::S_WB: state <= rvCore_pkg::S_FETCH;
        rvCore_pkg::S_HALT: ; // parked until reset.
        default: state <= rvCore_pkg::S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == rvCore_pkg::S_FETCH && coreRdValid) ir <= rdata;
    if (state == rvCore_pkg::S_DECODE) begin
      opA <= rs1Data;
      opB <= rs2Data;
    end
    if (state == rvCore_pkg::S_EXEC) aluOut <= aluResult;
    if (state == rvCore_pkg::S_MEM && coreRdValid) mdr <= rdata;
  end

  assign done = (state == rvCore_pkg::S_HALT);

endmodule

// File: cpuTop.sv
`timescale 1ns/1ns

module cpuTop (
  input  logic                  clk,
  input  logic                  arstN,
  input  logic                  start,
  input  rvCore_pkg::memReqType hostReq,
  output logic                  hostGnt,
  output logic                  hostRdValid,
  output logic [31:0]           hostRdata,
  output logic                  done
);

  rvCore_pkg::memReqType coreReq;
  rvCore_pkg::memReqType memReq;
  logic                  coreGnt;
  logic                  coreRdValid;
  logic [31:0]           memRdata;

  // one read port feeds both requesters.
  assign hostRdata = memRdata;

  core i_core (
    .clk(clk), .arstN(arstN), .start(start), .coreReq(coreReq),
    .coreGnt(coreGnt), .coreRdValid(coreRdValid), .rdata(memRdata), .done(done)
  );

  memArbiter i_memArbiter (
    .clk(clk), .arstN(arstN), .hostReq(hostReq), .coreReq(coreReq),
    .hostGnt(hostGnt), .coreGnt(coreGnt),
    .hostRdValid(hostRdValid), .coreRdValid(coreRdValid), .memReq(memReq)
  );

  unifiedMem i_unifiedMem (
    .clk(clk), .memReq(memReq), .rdata(memRdata)
  );

endmodule

// File: cpuTop_properties.sv
`timescale 1ns/1ns

module cpuTop_properties (
  input logic                  clk,
  input logic                  arstN,
  input rvCore_pkg::memReqType hostReq,
  input rvCore_pkg::memReqType coreReq,
  input logic                  hostGnt,
  input logic                  coreGnt,
  input logic                  hostRdValid,
  input logic                  coreRdValid,
  input logic                  done
);

  int failOneHot = 0;
  int failHolder = 0;
  int failHostFirst = 0;
  int failDone = 0;
  int failHostRd = 0;
  int failCoreRd = 0;
  logic [31:0] failCount;

  // summed for the testbench's closing line.
  assign failCount = failOneHot + failHolder + failHostFirst + failDone + failHostRd + failCoreRd;

  grantOneHot: assert property (@(posedge clk) disable iff (!arstN)
    $onehot0({hostGnt, coreGnt}))
    else begin
      $error("host and core granted in the same cycle");
      failOneHot++;
    end

  grantToHolder: assert property (@(posedge clk) disable iff (!arstN)
    (!hostGnt || hostReq.req) && (!coreGnt || coreReq.req))
    else begin
      $error("grant given to a requester without req");
      failHolder++;
    end

  hostFirst: assert property (@(posedge clk) disable iff (!arstN)
    hostReq.req |-> !coreGnt)
    else begin
      $error("core granted while the host requests");
      failHostFirst++;
    end

  doneHeld: assert property (@(posedge clk) disable iff (!arstN)
    done |=> done)
    else begin
      $error("done fell without a reset");
      failDone++;
    end

  hostRdFollows: assert property (@(posedge clk) disable iff (!arstN)
    (hostGnt && !hostReq.we) |=> hostRdValid)
    else begin
      $error("host read grant not followed by hostRdValid");
      failHostRd++;
    end

  coreRdFollows: assert property (@(posedge clk) disable iff (!arstN)
    (coreGnt && !coreReq.we) |=> coreRdValid)
    else begin
      $error("core read grant not followed by coreRdValid");
      failCoreRd++;
    end

endmodule

// File: memArbiter.sv
`timescale 1ns/1ns

module memArbiter (
  input  logic                  clk,
  input  logic                  arstN,
  input  rvCore_pkg::memReqType hostReq,
  input  rvCore_pkg::memReqType coreReq,
  output logic                  hostGnt,
  output logic                  coreGnt,
  output logic                  hostRdValid,
  output logic                  coreRdValid,
  output rvCore_pkg::memReqType memReq
);

  logic rdPending;
  logic rdHost;

  // host always wins.
  assign hostGnt = hostReq.req;
  assign coreGnt = coreReq.req & ~hostReq.req;
  assign memReq  = hostReq.req ? hostReq : coreReq;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      rdPending <= 1'b0;
      rdHost    <= 1'b0;
    end else begin
      rdPending <= (hostGnt & ~hostReq.we) | (coreGnt & ~coreReq.we);
      rdHost    <= hostGnt;
    end
  end

  assign hostRdValid = rdPending & rdHost;
  assign coreRdValid = rdPending & ~rdHost;

endmodule

// File: regFile.sv
`timescale 1ns/1ns

module regFile (
  input  logic        clk,
  input  logic        arstN,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  input  logic [4:0]  rd,
  input  logic        we,
  input  logic [31:0] wdata,
  output logic [31:0] rdata1,
  output logic [31:0] rdata2
);

  logic [31:0] regs [32];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < 32; i++) regs[i] <= '0;
    end else if (we && rd != 5'd0) begin
      regs[rd] <= wdata; // x0 never written.
    end
  end

  assign rdata1 = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
  assign rdata2 = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

endmodule

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module tb_cpuTop -o Vtb_cpuTop

# keep running past assertion errors so the testbench prints its status.
out=$(./obj_dir/Vtb_cpuTop +verilator+error+limit+1000)
echo "$out"
echo "$out" | grep -q "STATUS: PASS"

// File: rvCore_pkg.sv
`include "rv_config.svh"

package rvCore_pkg;

  typedef enum logic [6:0] {
    OP_IMM = 7'b0010011,
    OP     = 7'b0110011,
    LUI    = 7'b0110111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    SYSTEM = 7'b1110011
  } opcodeType;

  // field order matches the raw instruction word.
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcodeType  opcode;
  } instructionType;

  typedef enum logic [2:0] {R_TYPE, I_TYPE, S_TYPE, B_TYPE, U_TYPE} encodingType;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_LUI, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_XOR, ALU_OR, ALU_AND, ALU_SLT, ALU_SLTU
  } aluOpType;

  typedef enum logic [2:0] {
    BRANCH_NONE, BRANCH_BEQ, BRANCH_BNE, BRANCH_BLT,
    BRANCH_BGE, BRANCH_BLTU, BRANCH_BGEU
  } branchType;

  typedef struct packed {
    encodingType encoding;
    logic        regWrite;
    logic        aluSrc;     // b operand is the immediate.
    logic        memRead;
    logic        memWrite;
    logic        memToReg;
    logic        isBranch;
    logic        halt;
    aluOpType    aluOp;
    branchType   branchKind;
  } controlType;

  typedef enum logic [2:0] {
    S_IDLE, S_FETCH, S_DECODE, S_EXEC, S_MEM, S_WB, S_HALT
  } coreStateType;

  // shared by host and core requesters.
  typedef struct packed {
    logic                  req;
    logic                  we;
    logic [`ADDR_BITS-1:0] addr;   // word address.
    logic [31:0]           wdata;
  } memReqType;

endpackage

// File: rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// unified memory depth in 32-bit words.
`define MEM_WORDS 256

// word address width, log2 of the depth.
`define ADDR_BITS 8

`define RESET_PC 0

`endif

// File: tb_cpuTop.sv
`timescale 1ns/1ns
`include "rv_config.svh"

module tb_cpuTop;

  localparam int gntLimit = 100;
  localparam int runLimit = 20000;
  localparam logic [6:0] opImm    = 7'b0010011;
  localparam logic [6:0] opReg    = 7'b0110011;
  localparam logic [6:0] opLui    = 7'b0110111;
  localparam logic [6:0] opLoad   = 7'b0000011;
  localparam logic [6:0] opStore  = 7'b0100011;
  localparam logic [6:0] opBranch = 7'b1100011;
  localparam logic [31:0] ecall   = 32'h00000073;

  logic                  clk;
  logic                  arstN;
  logic                  start;
  rvCore_pkg::memReqType hostReq;
  logic                  hostGnt;
  logic                  hostRdValid;
  logic [31:0]           hostRdata;
  logic                  done;

  logic [31:0]           lfsr;
  logic [31:0]           prog [$];
  logic [`ADDR_BITS-1:0] expAddr [$];
  logic [31:0]           expVal [$];
  logic [31:0]           shadow [`MEM_WORDS];
  logic [31:0]           opA;
  logic [31:0]           opB;
  int                    errors;
  int                    checks;

  cpuTop i_cpuTop (
    .clk(clk), .arstN(arstN), .start(start), .hostReq(hostReq), .hostGnt(hostGnt),
    .hostRdValid(hostRdValid), .hostRdata(hostRdata), .done(done)
  );

  bind cpuTop cpuTop_properties i_cpuTopProperties (
    .clk(clk), .arstN(arstN), .hostReq(hostReq), .coreReq(coreReq), .hostGnt(hostGnt),
    .coreGnt(coreGnt), .hostRdValid(hostRdValid), .coreRdValid(coreRdValid), .done(done)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // taps 32, 22, 2, 1.
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic randBits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsrStep(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, opReg};
  endfunction

  function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  // sw only with funct3 fixed at word size.
  function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore};
  endfunction

  function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
  endfunction

  function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, opLui};
  endfunction

  function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                         input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0: begin
        if (alt) return a - b;
        else return a + b;
      end
      3'd1: return a << b[4:0];
      3'd2: return {31'd0, $signed(a) < $signed(b)};
      3'd3: return {31'd0, a < b};
      3'd4: return a ^ b;
      3'd5: begin
        if (alt) return $signed(a) >>> b[4:0];
        else return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branchRef(input logic [2:0] f3, input logic [31:0] a,
                                     input logic [31:0] b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      3'd7: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  task automatic checkValue(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp)
    else begin
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic hostWrite(input logic [`ADDR_BITS-1:0] addr, input logic [31:0] data);
    int waited;
    @(negedge clk);
    hostReq = '{req: 1'b1, we: 1'b1, addr: addr, wdata: data};
    waited = 0;
    @(posedge clk);
    while (!hostGnt && waited < gntLimit) begin
      @(posedge clk);
      waited++;
    end
    if (!hostGnt) begin
      $display("timeout: host write to %h was never granted", addr);
      errors++;
    end else begin
      checkValue("grantLatency", 32'd0, 32'(waited));
      shadow[addr] = data;
    end
    @(negedge clk);
    hostReq.req = 1'b0;
  endtask

  task automatic hostRead(input logic [`ADDR_BITS-1:0] addr, output logic [31:0] data);
    int waited;
    int lat;
    @(negedge clk);
    hostReq = '{req: 1'b1, we: 1'b0, addr: addr, wdata: 32'd0};
    waited = 0;
    @(posedge clk);
    while (!hostGnt && waited < gntLimit) begin
      @(posedge clk);
      waited++;
    end
    if (!hostGnt) begin
      $display("timeout: host read of %h was never granted", addr);
      errors++;
    end else begin
      checkValue("grantLatency", 32'd0, 32'(waited));
    end
    @(negedge clk);
    hostReq.req = 1'b0;
    lat = 1; // cycles since the grant edge.
    while (!hostRdValid && lat < gntLimit) begin
      @(negedge clk);
      lat++;
    end
    if (!hostRdValid) begin
      $display("timeout: host read data of %h never became valid", addr);
      errors++;
    end else begin
      checkValue("readLatency", 32'd1, 32'(lat));
    end
    data = hostRdata;
  endtask

  task automatic addExpected(input int addr, input logic [31:0] val);
    expAddr.push_back(`ADDR_BITS'(addr));
    expVal.push_back(val);
  endtask

  task automatic checkResults(input string name);
    logic [31:0] d;
    for (int i = 0; i < expAddr.size(); i++) begin
      hostRead(expAddr[i], d);
      checkValue($sformatf("%s[%0d]", name, i), expVal[i], d);
    end
  endtask

  task automatic hostReadBack();
    logic [31:0] a;
    logic [31:0] w;
    logic [31:0] d;
    logic [`ADDR_BITS-1:0] addrs [16];
    for (int i = 0; i < 16; i++) begin
      randBits(`ADDR_BITS, a);
      randBits(32, w);
      addrs[i] = a[`ADDR_BITS-1:0];
      hostWrite(addrs[i], w);
    end
    for (int i = 0; i < 16; i++) begin
      hostRead(addrs[i], d);
      checkValue($sformatf("hostReadBack[%0d]", i), shadow[addrs[i]], d);
    end
  endtask

  // operands at words 128 and 129 and results from word 160.
  task automatic buildArith();
    logic [2:0]  f3;
    logic        alt;
    logic [31:0] r;
    logic [11:0] imm;
    prog.delete();
    expAddr.delete();
    expVal.delete();
    randBits(32, opA);
    randBits(32, opB);
    prog.push_back(encI(12'd512, 5'd0, 3'b010, 5'd1, opLoad));
    prog.push_back(encI(12'd516, 5'd0, 3'b010, 5'd2, opLoad));
    for (int k = 0; k < 20; k++) begin
      alt = (k == 8 || k == 9 || k == 18); // sub, sra, srai.
      if (k < 8) f3 = 3'(k);
      else if (k == 8) f3 = 3'd0;
      else if (k == 9 || k == 18) f3 = 3'd5;
      else f3 = 3'(k - 10);
      randBits(20, r);
      if (k == 19) begin
        prog.push_back(encU(r[19:0], 5'd3));
        addExpected(160 + k, {r[19:0], 12'd0});
      end else if (k >= 10) begin
        imm = (f3 == 3'd1 || f3 == 3'd5) ? {alt ? 7'h20 : 7'h00, r[4:0]} : r[11:0];
        prog.push_back(encI(imm, 5'd1, f3, 5'd3, opImm));
        addExpected(160 + k, aluRef(f3, alt, opA, {{20{imm[11]}}, imm}));
      end else begin
        prog.push_back(encR(alt ? 7'h20 : 7'h00, 5'd2, 5'd1, f3, 5'd3));
        addExpected(160 + k, aluRef(f3, alt, opA, opB));
      end
      prog.push_back(encS(12'(640 + 4 * k), 5'd3, 5'd0));
    end
    prog.push_back(encI(12'd77, 5'd1, 3'd0, 5'd0, opImm)); // addi x0, x1, 77.
    prog.push_back(encS(12'd720, 5'd0, 5'd0));
    addExpected(180, 32'd0);
    prog.push_back(ecall);
  endtask

  task automatic buildBranch();
    logic [31:0] n;
    logic [2:0]  f3s [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    int          idx;
    prog.delete();
    expAddr.delete();
    expVal.delete();
    randBits(32, opA);
    randBits(32, opB);
    randBits(4, n);
    if (n == 0) n = 32'd15; // a zero count would wrap.
    prog.push_back(encI(12'd512, 5'd0, 3'b010, 5'd1, opLoad));
    prog.push_back(encI(12'd516, 5'd0, 3'b010, 5'd2, opLoad));
    prog.push_back(encI(n[11:0], 5'd0, 3'd0, 5'd5, opImm));
    prog.push_back(encI(12'd0, 5'd0, 3'd0, 5'd6, opImm));
    prog.push_back(encI(12'hFFF, 5'd5, 3'd0, 5'd5, opImm));
    prog.push_back(encI(12'd1, 5'd6, 3'd0, 5'd6, opImm));
    prog.push_back(encB(13'h1FF8, 5'd0, 5'd5, 3'b001)); // bne back two.
    prog.push_back(encS(12'd640, 5'd6, 5'd0));
    prog.push_back(encS(12'd644, 5'd5, 5'd0));
    addExpected(160, n);
    addExpected(161, 32'd0);
    for (int p = 0; p < 2; p++) begin
      for (int j = 0; j < 6; j++) begin
        idx = 6 * p + j;
        prog.push_back(encI(12'd1, 5'd0, 3'd0, 5'd7, opImm));
        prog.push_back(encB(13'd8, (p == 1) ? 5'd1 : 5'd2, 5'd1, f3s[j]));
        prog.push_back(encI(12'd0, 5'd0, 3'd0, 5'd7, opImm));
        prog.push_back(encS(12'(648 + 4 * idx), 5'd7, 5'd0));
        addExpected(162 + idx, {31'd0, branchRef(f3s[j], opA, (p == 1) ? opA : opB)});
      end
    end
    prog.push_back(ecall);
  endtask

  task automatic loadProgram();
    for (int i = 0; i < prog.size(); i++) hostWrite(`ADDR_BITS'(i), prog[i]);
    hostWrite(`ADDR_BITS'(128), opA);
    hostWrite(`ADDR_BITS'(129), opB);
    for (int a = 160; a < 192; a++) hostWrite(`ADDR_BITS'(a), {24'hFEED00, 8'(a)});
  endtask

  task automatic runCore(input logic traffic);
    int          cyc;
    int          reads;
    logic [31:0] d;
    @(negedge clk);
    start = 1'b1;
    cyc = 0;
    reads = 0;
    while (!done && cyc < runLimit) begin
      if (traffic) begin
        hostRead(`ADDR_BITS'(128 + reads % 2), d);
        checkValue("readUnderLoad", (reads % 2 == 0) ? opA : opB, d);
        reads++;
        cyc += 2;
      end else begin
        @(negedge clk);
        cyc++;
      end
    end
    if (!done) begin
      $display("timeout: core never raised done");
      errors++;
    end
    @(negedge clk);
    start = 1'b0;
  endtask

  task automatic holdAfterHalt();
    repeat (20) begin
      @(negedge clk);
      checkValue("doneHeld", 32'd1, {31'd0, done});
    end
  endtask

  task automatic resetDut();
    @(negedge clk);
    arstN = 1'b0;
    repeat (10) @(negedge clk);
    arstN = 1'b1;
  endtask

  initial begin
    arstN   = 1'b0;
    start   = 1'b0;
    hostReq = '0;
    errors  = 0;
    checks  = 0;
    lfsr    = 32'd68111;
    repeat (10) @(negedge clk);
    arstN = 1'b1;

    hostReadBack();

    buildArith();
    loadProgram();
    runCore(1'b0);
    checkResults("arith");
    holdAfterHalt();
    checkResults("afterHalt");

    resetDut();
    buildBranch();
    loadProgram();
    runCore(1'b0);
    checkResults("branch");

    resetDut();
    buildArith();
    loadProgram();
    runCore(1'b1);
    checkResults("underLoad");

    $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
             i_cpuTop.i_cpuTopProperties.failCount);
    if (errors == 0 && i_cpuTop.i_cpuTopProperties.failCount == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

// File: unifiedMem.sv
`timescale 1ns/1ns
`include "rv_config.svh"

module unifiedMem (
  input  logic                  clk,
  input  rvCore_pkg::memReqType memReq,
  output logic [31:0]           rdata
);

  logic [31:0] mem [`MEM_WORDS];

  always_ff @(posedge clk) begin
    if (memReq.req) begin
      if (memReq.we) begin
        mem[memReq.addr] <= memReq.wdata;
      end else begin
        rdata <= mem[memReq.addr]; // holds until the next read.
      end
    end
  end

endmodule
